//--- burst_mem_top.f
hdl/burst_pkg.sv
hdl/avmm_if.sv
hdl/sop_tracker.sv
hdl/burst_gearbox.sv
hdl/burst_mapper.sv
hdl/burst_memory.sv
hdl/burst_mem_top.sv
testbench/burst_mem_tb.sv

//--- hdl/avmm_if.sv
/*
 * Avalon-MM style memory bus with burst count, write responses and a user flag.
 * The master modport issues requests; the slave modport returns waitrequest and responses.
 */
`timescale 1ns/100ps
`default_nettype none

interface avmm_if
#(
    parameter int BURST_WIDTH = 3
)
(
    input logic clk,
    input logic reset_n
);
    import burst_pkg::*;

    // Request group
    logic read;
    logic write;
    addr_t address;
    logic [BURST_WIDTH-1:0] burstcount;
    data_t writedata;
    byteen_t byteenable;
    // Set on write bursts whose response must not reach the master
    logic user;
    logic waitrequest;

    // Response group
    logic readdatavalid;
    data_t readdata;
    resp_t response;
    logic writeresponsevalid;
    resp_t writeresponse;
    logic writeresponseuser;

    modport master
    (
        input clk, reset_n,
        output read, write, address, burstcount, writedata, byteenable, user,
        input waitrequest,
        input readdatavalid, readdata, response,
        input writeresponsevalid, writeresponse, writeresponseuser
    );

    modport slave
    (
        input clk, reset_n,
        input read, write, address, burstcount, writedata, byteenable, user,
        output waitrequest,
        output readdatavalid, readdata, response,
        output writeresponsevalid, writeresponse, writeresponseuser
    );

endinterface

`default_nettype wire

//--- hdl/burst_gearbox.sv
/*
 * Splits one master burst request into a run of slave-sized sub-bursts.
 * Load with m_new_req, then step with s_accept_req once per issued sub-burst.
 */
`timescale 1ns/100ps
`default_nettype none

module burst_gearbox
#(
    parameter int MASTER_BURST_WIDTH = 5,
    parameter int SLAVE_BURST_WIDTH = 3,
    parameter int NATURAL_ALIGNMENT = 0
)
(
    input logic clk,
    input logic reset_n,

    input logic m_new_req,
    input burst_pkg::addr_t m_addr,
    input logic [MASTER_BURST_WIDTH-1:0] m_burstcount,

    input logic s_accept_req,
    output logic s_req_complete,
    output burst_pkg::addr_t s_addr,
    output logic [SLAVE_BURST_WIDTH-1:0] s_burstcount
);
    import burst_pkg::*;

    // Largest count the slave takes, 4 beats for a 3-bit count
    localparam logic [MASTER_BURST_WIDTH-1:0] MAX_BEATS =
        MASTER_BURST_WIDTH'(1 << (SLAVE_BURST_WIDTH - 1));

    addr_t next_addr;
    logic [MASTER_BURST_WIDTH-1:0] beats_left;
    // Size limited by the slave only, then further limited by alignment
    logic [MASTER_BURST_WIDTH-1:0] cap_size;
    logic [MASTER_BURST_WIDTH-1:0] sub_size;

    always_comb
    begin
        if (beats_left > MAX_BEATS)
            cap_size = MAX_BEATS;
        else
            cap_size = beats_left;

        sub_size = cap_size;

        if (NATURAL_ALIGNMENT != 0)
        begin
            // Pick the largest power of two that fits and divides the address.
            // Walking upward lets each larger legal size overwrite the last
            sub_size = '0;
            for (int i = 0; i < SLAVE_BURST_WIDTH; i++)
            begin
                if ((MASTER_BURST_WIDTH'(1 << i) <= cap_size) &&
                    ((next_addr & addr_t'((1 << i) - 1)) == '0))
                    sub_size = MASTER_BURST_WIDTH'(1 << i);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            beats_left <= '0;
        end
        else if (m_new_req)
        begin
            // A new master burst replaces whatever is left of the old one
            beats_left <= m_burstcount;
            next_addr <= m_addr;
        end
        else if (s_accept_req)
        begin
            beats_left <= beats_left - sub_size;
            next_addr <= next_addr + addr_t'(sub_size);
        end
    end

    assign s_addr = next_addr;
    assign s_burstcount = SLAVE_BURST_WIDTH'(sub_size);

    // Also high when idle, so an empty gearbox never stalls the master
    assign s_req_complete = (beats_left == sub_size);

endmodule

`default_nettype wire

//--- hdl/burst_mapper.sv
/*
 * Adapts master bursts of up to 16 beats onto a slave limited to shorter bursts.
 * Sits between two avmm_if instances that differ only in burst count width.
 */
`timescale 1ns/100ps
`default_nettype none

module burst_mapper
#(
    parameter int NATURAL_ALIGNMENT = 0
)
(
    avmm_if.slave mem_master,
    avmm_if.master mem_slave
);
    import burst_pkg::*;

    localparam int MASTER_BURST_WIDTH = $bits(mem_master.burstcount);
    localparam int SLAVE_BURST_WIDTH = $bits(mem_slave.burstcount);

    logic clk;
    logic reset_n;

    logic req_complete;
    logic m_new_req;
    logic s_accept_req;
    logic m_wr_sop;
    logic s_wr_sop;
    addr_t s_address;
    logic [SLAVE_BURST_WIDTH-1:0] s_burstcount;

    assign clk = mem_master.clk;
    assign reset_n = mem_master.reset_n;

    // The master waits while the memory waits, and while a read still has
    // sub-bursts to issue. Write beats map one to one, so they never add stalls
    assign mem_master.waitrequest = mem_slave.waitrequest ||
                                    (mem_slave.read && !req_complete);

    // Reads and the first beat of each write start a new master request
    assign m_new_req = !mem_master.waitrequest && m_wr_sop &&
                       (mem_master.read || mem_master.write);

    // The slave takes a sub-burst on a read or on the first beat of a write
    assign s_accept_req = !mem_slave.waitrequest && s_wr_sop &&
                          (mem_slave.read || mem_slave.write);

    burst_gearbox
    #(
        .MASTER_BURST_WIDTH(MASTER_BURST_WIDTH),
        .SLAVE_BURST_WIDTH(SLAVE_BURST_WIDTH),
        .NATURAL_ALIGNMENT(NATURAL_ALIGNMENT)
    )
    gearbox
    (
        .clk(clk),
        .reset_n(reset_n),
        .m_new_req(m_new_req),
        .m_addr(mem_master.address),
        .m_burstcount(mem_master.burstcount),
        .s_accept_req(s_accept_req),
        .s_req_complete(req_complete),
        .s_addr(s_address),
        .s_burstcount(s_burstcount)
    );

    // Request strobes move one stage forward whenever the master is not stalled
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            mem_slave.read <= 1'b0;
            mem_slave.write <= 1'b0;
        end
        else if (!mem_master.waitrequest)
        begin
            mem_slave.read <= mem_master.read;
            mem_slave.write <= mem_master.write;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!mem_master.waitrequest)
        begin
            mem_slave.writedata <= mem_master.writedata;
            mem_slave.byteenable <= mem_master.byteenable;
        end
    end

    // Address and count come from the gearbox and matter only on slave SOP beats
    assign mem_slave.address = s_address;
    assign mem_slave.burstcount = s_burstcount;

    // Every write sub-burst but the last asks the memory to tag its response
    assign mem_slave.user = mem_slave.write && !req_complete;

    // Read data carries no burst framing and goes straight back
    assign mem_master.readdatavalid = mem_slave.readdatavalid;
    assign mem_master.readdata = mem_slave.readdata;
    assign mem_master.response = mem_slave.response;

    // Tagged write responses are swallowed, leaving one per master burst
    assign mem_master.writeresponsevalid = mem_slave.writeresponsevalid &&
                                           !mem_slave.writeresponseuser;
    assign mem_master.writeresponse = mem_slave.writeresponse;
    assign mem_master.writeresponseuser = mem_slave.writeresponseuser;

    // Master side counts master write beats, slave side counts sub-burst beats
    sop_tracker
    #(
        .BURST_CNT_WIDTH(MASTER_BURST_WIDTH)
    )
    m_sop_tracker
    (
        .clk(clk),
        .reset_n(reset_n),
        .flit_valid(mem_master.write && !mem_master.waitrequest),
        .burstcount(mem_master.burstcount),
        .sop(m_wr_sop)
    );

    sop_tracker
    #(
        .BURST_CNT_WIDTH(SLAVE_BURST_WIDTH)
    )
    s_sop_tracker
    (
        .clk(clk),
        .reset_n(reset_n),
        .flit_valid(mem_slave.write && !mem_slave.waitrequest),
        .burstcount(mem_slave.burstcount),
        .sop(s_wr_sop)
    );

endmodule

`default_nettype wire

//--- hdl/burst_mem_top.sv
/*
 * Top level of the burst-limited memory, with a plain Avalon-MM master port.
 * Master bursts of up to 16 beats are split before they reach the memory.
 */
`timescale 1ns/100ps
`default_nettype none

module burst_mem_top
#(
    parameter int MASTER_BURST_WIDTH = 5,
    parameter int SLAVE_BURST_WIDTH = 3,
    parameter int NATURAL_ALIGNMENT = 0
)
(
    input logic clk,
    input logic reset_n,

    input logic read,
    input logic write,
    input burst_pkg::addr_t address,
    input logic [MASTER_BURST_WIDTH-1:0] burstcount,
    input burst_pkg::data_t writedata,
    input burst_pkg::byteen_t byteenable,
    output logic waitrequest,

    output logic readdatavalid,
    output burst_pkg::data_t readdata,
    output burst_pkg::resp_t response,
    output logic writeresponsevalid,
    output burst_pkg::resp_t writeresponse
);

    avmm_if #(.BURST_WIDTH(MASTER_BURST_WIDTH)) m_bus (.clk(clk), .reset_n(reset_n));
    avmm_if #(.BURST_WIDTH(SLAVE_BURST_WIDTH)) s_bus (.clk(clk), .reset_n(reset_n));

    // Master request side, the outside master never asks for tagged responses
    assign m_bus.read = read;
    assign m_bus.write = write;
    assign m_bus.address = address;
    assign m_bus.burstcount = burstcount;
    assign m_bus.writedata = writedata;
    assign m_bus.byteenable = byteenable;
    assign m_bus.user = 1'b0;
    assign waitrequest = m_bus.waitrequest;

    assign readdatavalid = m_bus.readdatavalid;
    assign readdata = m_bus.readdata;
    assign response = m_bus.response;
    assign writeresponsevalid = m_bus.writeresponsevalid;
    assign writeresponse = m_bus.writeresponse;

    burst_mapper
    #(
        .NATURAL_ALIGNMENT(NATURAL_ALIGNMENT)
    )
    mapper
    (
        .mem_master(m_bus.slave),
        .mem_slave(s_bus.master)
    );

    burst_memory
    #(
        .BURST_WIDTH(SLAVE_BURST_WIDTH)
    )
    memory
    (
        .bus(s_bus.slave)
    );

endmodule

`default_nettype wire

//--- hdl/burst_memory.sv
/*
 * 1024-word on-chip memory slave with burst reads and byte-enabled burst writes.
 * Returns one write response per slave burst, tagged with the burst's user flag.
 */
`timescale 1ns/100ps
`default_nettype none

module burst_memory
#(
    parameter int BURST_WIDTH = 3
)
(
    avmm_if.slave bus
);
    import burst_pkg::*;

    logic clk;
    logic reset_n;

    data_t mem [0:(1 << $bits(addr_t))-1];

    mem_state_t state;

    // Read stream position
    logic rd_start;
    logic rd_beat;
    addr_t rd_beat_addr;
    addr_t rd_addr;
    logic [BURST_WIDTH-1:0] rd_left;

    // Write burst position, zero beats left means the next beat starts a burst
    logic wr_fire;
    logic wr_first;
    addr_t wr_beat_addr;
    addr_t wr_addr;
    logic wr_beat_user;
    logic wr_user;
    logic [BURST_WIDTH-1:0] wr_left;
    logic [BURST_WIDTH-1:0] wr_left_next;

    assign clk = bus.clk;
    assign reset_n = bus.reset_n;

    // New requests are refused while a read burst is streaming out
    assign bus.waitrequest = (state == MEM_READ);

    assign rd_start = bus.read && !bus.waitrequest;
    assign rd_beat = rd_start || (state == MEM_READ);
    assign rd_beat_addr = (state == MEM_IDLE) ? bus.address : rd_addr;

    assign wr_fire = bus.write && !bus.waitrequest;
    assign wr_first = (wr_left == '0);
    assign wr_beat_addr = wr_first ? bus.address : wr_addr;
    assign wr_beat_user = wr_first ? bus.user : wr_user;
    assign wr_left_next = (wr_first ? bus.burstcount : wr_left) - BURST_WIDTH'(1);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= MEM_IDLE;
            wr_left <= '0;
            bus.readdatavalid <= 1'b0;
            bus.writeresponsevalid <= 1'b0;
        end
        else
        begin
            bus.readdatavalid <= rd_beat;
            // Respond in the cycle after the burst's last beat
            bus.writeresponsevalid <= wr_fire && (wr_left_next == '0);

            if (wr_fire)
                wr_left <= wr_left_next;

            case (state)
                MEM_IDLE:
                    if (rd_start && (bus.burstcount != BURST_WIDTH'(1)))
                        state <= MEM_READ;
                MEM_READ:
                    if (rd_left == BURST_WIDTH'(1))
                        state <= MEM_IDLE;
                default:
                    state <= MEM_IDLE;
            endcase
        end
    end

    // Storage, read data and burst bookkeeping
    always_ff @(posedge clk)
    begin
        if (rd_beat)
        begin
            bus.readdata <= mem[rd_beat_addr];
            rd_addr <= rd_beat_addr + addr_t'(1);
            rd_left <= (rd_start ? bus.burstcount : rd_left) - BURST_WIDTH'(1);
        end

        if (wr_fire)
        begin
            for (int b = 0; b < $bits(byteen_t); b++)
            begin
                if (bus.byteenable[b])
                    mem[wr_beat_addr][8*b +: 8] <= bus.writedata[8*b +: 8];
            end
            wr_addr <= wr_beat_addr + addr_t'(1);
            wr_user <= wr_beat_user;
            bus.writeresponseuser <= wr_beat_user;
        end
    end

    assign bus.response = RESP_OKAY;
    assign bus.writeresponse = RESP_OKAY;

endmodule

`default_nettype wire

//--- hdl/burst_pkg.sv
/*
 * Shared types for the burst-limited memory subsystem.
 * Imported by the interface, the mapper, the gearbox and the memory.
 */
`default_nettype none

package burst_pkg;

    // Word address into the 1024-word memory
    typedef logic [9:0] addr_t;

    // One data word and its byte enables
    typedef logic [31:0] data_t;
    typedef logic [3:0] byteen_t;

    // Response code, only OKAY is ever produced
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY = 2'b00;

    // Read streaming state of the memory
    typedef enum logic {
        MEM_IDLE,
        MEM_READ
    } mem_state_t;

endpackage

`default_nettype wire

//--- hdl/sop_tracker.sv
/*
 * Marks the first beat of each write burst by counting beats against the burst count.
 * Feed it every accepted write beat; sop is valid for the beat currently presented.
 */
`timescale 1ns/100ps
`default_nettype none

module sop_tracker
#(
    parameter int BURST_CNT_WIDTH = 3
)
(
    input logic clk,
    input logic reset_n,
    input logic flit_valid,
    input logic [BURST_CNT_WIDTH-1:0] burstcount,
    output logic sop
);

    // Beats still expected after the current one in the open burst
    logic [BURST_CNT_WIDTH-1:0] beats_left;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            sop <= 1'b1;
            beats_left <= '0;
        end
        else if (flit_valid)
        begin
            if (sop)
            begin
                // The burst count is only meaningful on the first beat
                beats_left <= burstcount - BURST_CNT_WIDTH'(1);
                sop <= (burstcount == BURST_CNT_WIDTH'(1));
            end
            else
            begin
                beats_left <= beats_left - BURST_CNT_WIDTH'(1);
                sop <= (beats_left == BURST_CNT_WIDTH'(1));
            end
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build the burst memory testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps --top-module burst_mem_tb \
    -f burst_mem_top.f -o burst_mem_sim &&
./obj_dir/burst_mem_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "Simulation run succeeded" ||
{ echo "Simulation run failed"; exit 1; }

//--- testbench/burst_mem_tb.sv
/*
 * Directed testbench for the burst-limited memory, driving the plain Avalon-MM master port.
 * A reference array predicts every read word; run it through the file list.
 */
`timescale 1ns/100ps
`default_nettype none

module burst_mem_tb;
    import burst_pkg::*;

    localparam int MASTER_BURST_WIDTH = 5;
    localparam int SLAVE_BURST_WIDTH = 3;
    localparam int MEM_WORDS = 1024;
    // Longest wait in clock cycles allowed for any handshake
    localparam int TIMEOUT = 200;
    // Cycles watched for stray read data or write responses
    localparam int QUIET_CYCLES = 24;

    logic clk;
    logic reset_n;
    logic read;
    logic write;
    addr_t address;
    logic [MASTER_BURST_WIDTH-1:0] burstcount;
    data_t writedata;
    byteen_t byteenable;
    logic waitrequest;
    logic readdatavalid;
    data_t readdata;
    resp_t response;
    logic writeresponsevalid;
    resp_t writeresponse;

    // Expected memory contents are updated on every write beat the testbench issues
    data_t ref_mem [0:MEM_WORDS-1];
    logic [31:0] lfsr_state;

    // Read beats and write responses seen on the master port
    data_t rd_q[$];
    resp_t rd_resp_q[$];
    int wresp_count = 0;
    resp_t wresp_last;
    // Write responses the tests have asked for so far
    int resp_expected = 0;

    burst_mem_top
    #(
        .MASTER_BURST_WIDTH(MASTER_BURST_WIDTH),
        .SLAVE_BURST_WIDTH(SLAVE_BURST_WIDTH),
        .NATURAL_ALIGNMENT(0)
    )
    DUT
    (
        .clk(clk),
        .reset_n(reset_n),
        .read(read),
        .write(write),
        .address(address),
        .burstcount(burstcount),
        .writedata(writedata),
        .byteenable(byteenable),
        .waitrequest(waitrequest),
        .readdatavalid(readdatavalid),
        .readdata(readdata),
        .response(response),
        .writeresponsevalid(writeresponsevalid),
        .writeresponse(writeresponse)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Outputs only change on the rising edge, so the falling edge sees them settled
    always @(negedge clk)
    begin
        if (readdatavalid === 1'b1)
        begin
            rd_q.push_back(readdata);
            rd_resp_q.push_back(response);
        end
        if (writeresponsevalid === 1'b1)
        begin
            wresp_count++;
            wresp_last = writeresponse;
        end
    end

    // Taps 32, 22, 2 and 1 give a maximal length sequence
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++)
            val = {val[30:0], lfsr_bit()};
        return val;
    endfunction

    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("ERROR %s: expected %h, actual %h", test_name, expected, actual);
            stop_with_failure();
        end
    endtask

    // Called on a falling edge with the beat already driven
    task automatic wait_accept(input string test_name);
        int cycles;
        cycles = 0;
        while (waitrequest !== 1'b0)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT)
            begin
                $display("Timeout in %s: waitrequest never dropped", test_name);
                stop_with_failure();
            end
        end
        // The beat transfers on the rising edge in between
        @(negedge clk);
    endtask

    task automatic write_burst(input string test_name, input addr_t addr, input int beats,
                               input logic partial);
        data_t word;
        byteen_t be;
        addr_t beat_addr;
        for (int i = 0; i < beats; i++)
        begin
            word = random_bits(32);
            be = partial ? byteen_t'(random_bits(4)) : 4'hF;
            beat_addr = addr + addr_t'(i);
            write = 1'b1;
            address = addr;
            burstcount = MASTER_BURST_WIDTH'(beats);
            writedata = word;
            byteenable = be;
            // Only the enabled bytes of the word land in memory
            for (int b = 0; b < 4; b++)
            begin
                if (be[b])
                    ref_mem[beat_addr][8*b +: 8] = word[8*b +: 8];
            end
            wait_accept(test_name);
        end
        write = 1'b0;
    endtask

    // Must follow write_burst directly, before the response can have arrived
    task automatic finish_write(input string test_name);
        int cycles;
        cycles = 0;
        @(posedge clk);
        check_value(test_name, 32'(resp_expected), 32'(wresp_count));
        resp_expected++;
        while (wresp_count < resp_expected)
        begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT)
            begin
                $display("Timeout in %s: no write response arrived", test_name);
                stop_with_failure();
            end
        end
        check_value(test_name, 32'(resp_expected), 32'(wresp_count));
        check_value(test_name, 32'(RESP_OKAY), 32'(wresp_last));
        @(negedge clk);
    endtask

    task automatic read_burst(input string test_name, input addr_t addr, input int beats);
        read = 1'b1;
        address = addr;
        burstcount = MASTER_BURST_WIDTH'(beats);
        wait_accept(test_name);
        read = 1'b0;
    endtask

    task automatic collect_reads(input string test_name, input addr_t addr, input int beats);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (rd_q.size() < beats)
        begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT)
            begin
                $display("Timeout in %s: read data stopped short", test_name);
                stop_with_failure();
            end
        end
        // Words must come back in address order
        for (int i = 0; i < beats; i++)
        begin
            check_value(test_name, ref_mem[addr + addr_t'(i)], rd_q.pop_front());
            check_value(test_name, 32'(RESP_OKAY), 32'(rd_resp_q.pop_front()));
        end
        @(negedge clk);
    endtask

    // Nothing more may show up once a test has taken what it asked for
    task automatic expect_quiet(input string test_name);
        repeat (QUIET_CYCLES) @(posedge clk);
        check_value(test_name, 32'd0, 32'(rd_q.size()));
        check_value(test_name, 32'(resp_expected), 32'(wresp_count));
        @(negedge clk);
    endtask

    task automatic single_beat_roundtrip();
        addr_t addr;
        addr = addr_t'(random_bits(10));
        write_burst("single_beat", addr, 1, 1'b0);
        finish_write("single_beat");
        read_burst("single_beat", addr, 1);
        collect_reads("single_beat", addr, 1);
        expect_quiet("single_beat");
    endtask

    // Sixteen beats become four slave sub-bursts that the master never sees
    task automatic long_burst_roundtrip();
        write_burst("long_burst", 10'h100, 16, 1'b0);
        finish_write("long_burst");
        read_burst("long_burst", 10'h100, 16);
        collect_reads("long_burst", 10'h100, 16);
        expect_quiet("long_burst");
    endtask

    task automatic one_response_per_burst();
        int lengths[5] = '{1, 3, 5, 7, 13};
        for (int k = 0; k < 5; k++)
        begin
            write_burst("write_responses", addr_t'(10'h200 + 16 * k), lengths[k], 1'b0);
            finish_write("write_responses");
            expect_quiet("write_responses");
        end
    endtask

    // Full words first, so the partial burst merges over known data
    task automatic byte_enable_merge();
        write_burst("byte_enables", 10'h300, 8, 1'b0);
        finish_write("byte_enables");
        write_burst("byte_enables", 10'h300, 8, 1'b1);
        finish_write("byte_enables");
        read_burst("byte_enables", 10'h300, 8);
        collect_reads("byte_enables", 10'h300, 8);
        expect_quiet("byte_enables");
    endtask

    task automatic unaligned_bursts();
        write_burst("unaligned", 10'h12B, 9, 1'b0);
        finish_write("unaligned");
        read_burst("unaligned", 10'h12B, 9);
        collect_reads("unaligned", 10'h12B, 9);
        expect_quiet("unaligned");
        // Second read is presented the moment the first one is taken
        read_burst("back_to_back", 10'h12D, 2);
        read_burst("back_to_back", 10'h100, 16);
        collect_reads("back_to_back", 10'h12D, 2);
        collect_reads("back_to_back", 10'h100, 16);
        expect_quiet("back_to_back");
    endtask

    initial
    begin
        lfsr_state = 32'h3534;
        reset_n = 1'b0;
        read = 1'b0;
        write = 1'b0;
        address = '0;
        burstcount = MASTER_BURST_WIDTH'(1);
        writedata = '0;
        byteenable = '0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        single_beat_roundtrip();
        long_burst_roundtrip();
        one_response_per_burst();
        byte_enable_merge();
        unaligned_bursts();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
